// ==== rv_core.f ====
hw/rv_pkg.sv
hw/decode_if.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/lsu.sv
hw/core_ctrl.sv
hw/rv_core.sv
testbench/tb_clock.sv
testbench/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || exit 1
exit 0

// ==== testbench/rv_core_tests.mem ====
// columns: kind (1 program word, 2 expected store, 0 end) address data strobes
// program: alu ops, upper immediates, loads, x0, branches, jumps, halt
1 00000000 10000513 0
1 00000004 20000593 0
1 00000008 00700093 0
1 0000000c ffd00113 0
1 00000010 402081b3 0
1 00000014 00352023 0
1 00000018 40115233 0
1 0000001c 00452223 0
1 00000020 001122b3 0
1 00000024 0020b333 0
1 00000028 00431313 0
1 0000002c 0062e3b3 0
1 00000030 00752423 0
1 00000034 12345437 0
1 00000038 00001497 0
1 0000003c 00940433 0
1 00000040 00852623 0
1 00000044 00058603 0
1 00000048 00c52823 0
1 0000004c 0025d683 0
1 00000050 00d51a23 0
1 00000054 00259703 0
1 00000058 00e52c23 0
1 0000005c 0015c783 0
1 00000060 00f50fa3 0
1 00000064 00500013 0
1 00000068 02052023 0
1 0000006c 00108463 0
1 00000070 00180813 0
1 00000074 00208463 0
1 00000078 00280813 0
1 0000007c 00209463 0
1 00000080 00480813 0
1 00000084 00109463 0
1 00000088 00880813 0
1 0000008c 00114463 0
1 00000090 01080813 0
1 00000094 0020c463 0
1 00000098 02080813 0
1 0000009c 0020d463 0
1 000000a0 04080813 0
1 000000a4 00115463 0
1 000000a8 08080813 0
1 000000ac 0020e463 0
1 000000b0 10080813 0
1 000000b4 00116463 0
1 000000b8 20080813 0
1 000000bc 0020f463 0
1 000000c0 40080813 0
1 000000c4 00117463 0
1 000000c8 80080813 0
1 000000cc 03052223 0
1 000000d0 008008ef 0
1 000000d4 00052023 0
1 000000d8 03152423 0
1 000000dc 0e800993 0
1 000000e0 00198967 0
1 000000e4 00052023 0
1 000000e8 03252623 0
1 000000ec 0ff0000f 0
1 000000f0 00000073 0
1 000000f4 00052023 0
// load data word
1 00000200 8765f0f1 0
// expected stores in program order
2 00000100 0000000a f
2 00000104 ffffffff f
2 00000108 00000011 f
2 0000010c 12346038 f
2 00000110 fffffff1 f
2 00000114 87658765 3
2 00000118 ffff8765 f
2 0000011f f0f0f0f0 8
2 00000120 00000000 f
2 00000124 000006aa f
2 00000128 000000d4 f
2 0000012c 000000e4 f
0 00000000 00000000 0

// ==== testbench/rv_core_tb.sv ====
// testbench for the rv32i core with a four-phase memory model and store checking
module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS   = 256;
    localparam int TEST_WORDS  = 512;
    localparam int WAIT_LIMIT  = 200;
    localparam int HALT_LIMIT  = 20000;

    logic             clk;
    logic             rst;
    logic             mem_ack;
    rv_pkg::word_t    mem_rdata;
    logic             mem_req;
    logic             mem_we;
    rv_pkg::word_t    mem_addr;
    rv_pkg::word_t    mem_wdata;
    rv_pkg::byte_en_t mem_be;
    logic             halted;

    rv_pkg::word_t mem [MEM_WORDS];
    logic [31:0]   tests [TEST_WORDS];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    rv_pkg::byte_en_t exp_be [$];
    int            store_count;
    int            seed;
    bit            data_next;

    tb_clock u_clock (.clk(clk), .rst(rst));

    rv_core uut (
        .clk       (clk),
        .rst       (rst),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .halted    (halted)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        if (exp !== act) begin
            stop_with_error($sformatf("mismatch at %0d ns: %s expected %h actual %h",
                                      $time, name, exp, act));
        end
    endtask

    task automatic check_be(input string name, input rv_pkg::byte_en_t exp,
                            input rv_pkg::byte_en_t act);
        if (exp !== act) begin
            stop_with_error($sformatf("mismatch at %0d ns: %s expected %b actual %b",
                                      $time, name, exp, act));
        end
    endtask

    // kind 1 is a program word and kind 2 an expected store, any other kind ends the list
    task automatic load_tests();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = rv_pkg::word_t'(i << 2) ^ 32'ha5c3_0000;
        end
        $readmemh("testbench/rv_core_tests.mem", tests);
        for (i = 0; i + 3 < TEST_WORDS; i += 4) begin
            if (tests[i] === 32'd1) begin
                mem[tests[i + 1][9:2]] = tests[i + 2];
            end else if (tests[i] === 32'd2) begin
                exp_addr.push_back(tests[i + 1]);
                exp_data.push_back(tests[i + 2]);
                exp_be.push_back(tests[i + 3][3:0]);
            end else begin
                break;
            end
        end
    endtask

    task automatic check_store();
        int b;
        if (store_count >= exp_addr.size()) begin
            stop_with_error($sformatf("unexpected extra store to %h at %0d ns",
                                      mem_addr, $time));
        end
        check_word("mem_addr", exp_addr[store_count], mem_addr);
        check_word("mem_wdata", exp_data[store_count], mem_wdata);
        check_be("mem_be", exp_be[store_count], mem_be);
        for (b = 0; b < 4; b++) begin
            if (mem_be[b]) begin
                mem[mem_addr[9:2]][8 * b +: 8] = mem_wdata[8 * b +: 8];
            end
        end
        store_count++;
    endtask

    // serve one four-phase transfer and flag done once the core has halted
    task automatic serve_access(output bit done);
        int n;
        int delay;
        rv_pkg::word_t rdata;
        done = 1'b0;
        n = 0;
        @(negedge clk);
        while (!mem_req && !halted) begin
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("core issued no bus request in time");
            end
            @(negedge clk);
        end
        if (!mem_req) begin
            done = 1'b1;
            return;
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(negedge clk);
            if (!mem_req) begin
                stop_with_error("mem_req dropped before mem_ack was raised");
            end
        end
        if (mem_we) begin
            check_store();
        end else if (!data_next) begin
            // instruction fetches read the whole word
            check_be("mem_be", 4'b1111, mem_be);
        end
        rdata = mem[mem_addr[9:2]];
        if (data_next) begin
            data_next = 1'b0;
        end else begin
            // a fetched load or store is followed by its data access
            data_next = rdata[6:0] inside {7'b0000011, 7'b0100011};
        end
        @(posedge clk);
        mem_ack   <= 1'b1;
        mem_rdata <= rdata;
        n = 0;
        @(negedge clk);
        while (mem_req) begin
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("core held mem_req after mem_ack");
            end
            @(negedge clk);
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(negedge clk);
            if (mem_req) begin
                stop_with_error("mem_req raised again while mem_ack was high");
            end
        end
        @(posedge clk);
        mem_ack <= 1'b0;
    endtask

    initial begin
        bit done;
        int n;
        mem_ack     = 1'b0;
        mem_rdata   = '0;
        store_count = 0;
        data_next   = 1'b0;
        seed        = 32'h7c7b;
        load_tests();
        n = 0;
        @(negedge clk);
        while (rst) begin
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_error("reset never released");
            end
            @(negedge clk);
        end
        if (mem_req || mem_we || halted) begin
            stop_with_error("bus or halted not idle after reset");
        end
        n = 0;
        done = 1'b0;
        while (!done) begin
            n++;
            if (n > HALT_LIMIT) begin
                stop_with_error("core did not halt in time");
            end
            serve_access(done);
        end
        // after halting the bus must stay quiet
        repeat (20) begin
            @(negedge clk);
            if (mem_req) begin
                stop_with_error("mem_req raised after halt");
            end
        end
        if (store_count != exp_addr.size()) begin
            stop_with_error($sformatf("saw %0d stores but expected %0d",
                                      store_count, exp_addr.size()));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== testbench/tb_clock.sv ====
// testbench clock and reset source with a 4 ns period and 4 reset cycles
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== hw/rv_core.sv ====
// rv32i multi-cycle core top level with one shared req/ack memory bus
module rv_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_ack,
    input  rv_pkg::word_t    mem_rdata,
    output logic             mem_req,
    output logic             mem_we,
    output rv_pkg::word_t    mem_addr,
    output rv_pkg::word_t    mem_wdata,
    output rv_pkg::byte_en_t mem_be,
    output logic             halted
);
    import rv_pkg::*;

    decode_if dec ();

    instr_t   instr;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_result;
    word_t    load_data;
    word_t    rf_wdata;
    byte_en_t lsu_be;
    logic     branch_taken;
    logic     rf_we;
    logic     addr_phase_data;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec.decoder)
    );

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .ra1 (dec.rs1),
        .ra2 (dec.rs2),
        .wa  (dec.rd),
        .we  (rf_we),
        .wd  (rf_wdata),
        .rd1 (rs1_val),
        .rd2 (rs2_val)
    );

    alu u_alu (
        .dec          (dec.ctrl),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .pc           (pc),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    lsu u_lsu (
        .dec       (dec.ctrl),
        .addr      (mem_addr),
        .store_val (rs2_val),
        .mem_word  (mem_rdata),
        .wdata     (mem_wdata),
        .be        (lsu_be),
        .load_data (load_data)
    );

    core_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .mem_ack         (mem_ack),
        .mem_rdata       (mem_rdata),
        .alu_result      (alu_result),
        .branch_taken    (branch_taken),
        .load_data       (load_data),
        .dec             (dec.ctrl),
        .instr           (instr),
        .pc              (pc),
        .mem_req         (mem_req),
        .rf_we           (rf_we),
        .rf_wdata        (rf_wdata),
        .addr_phase_data (addr_phase_data),
        .halted          (halted)
    );

    // fetches read a full word at the pc
    assign mem_addr = addr_phase_data ? alu_result : pc;
    assign mem_we   = addr_phase_data && dec.mem_write;
    assign mem_be   = addr_phase_data ? lsu_be : 4'b1111;

endmodule

// ==== hw/core_ctrl.sv ====
// core control with the FSM, pc, instruction register and four-phase bus handshake
module core_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_ack,
    input  rv_pkg::word_t  mem_rdata,
    input  rv_pkg::word_t  alu_result,
    input  logic           branch_taken,
    input  rv_pkg::word_t  load_data,
    decode_if.ctrl         dec,
    output rv_pkg::instr_t instr,
    output rv_pkg::word_t  pc,
    output logic           mem_req,
    output logic           rf_we,
    output rv_pkg::word_t  rf_wdata,
    output logic           addr_phase_data,
    output logic           halted
);
    import rv_pkg::*;

    typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB, S_HALT} state_t;

    state_t state;
    logic   ack_seen;
    word_t  mdr;
    word_t  pc_plus4;
    word_t  next_pc;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (!branch_taken) begin
            next_pc = pc_plus4;
        end else if (dec.is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else begin
            next_pc = alu_result;
        end
    end

    always_comb begin
        case (dec.wb_sel)
            WB_MEM:       rf_wdata = mdr;
            WB_PC_PLUS_4: rf_wdata = pc_plus4;
            default:      rf_wdata = alu_result;
        endcase
    end

    assign rf_we           = (state == S_WB) && dec.wb_en;
    assign addr_phase_data = (state == S_MEM);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_FETCH;
            pc       <= RESET_PC;
            instr    <= '0;
            mem_req  <= 1'b0;
            ack_seen <= 1'b0;
            halted   <= 1'b0;
        end else begin
            case (state)
                S_FETCH, S_MEM: begin
                    if (!ack_seen) begin
                        if (mem_req && mem_ack) begin
                            mem_req  <= 1'b0;
                            ack_seen <= 1'b1;
                            if (state == S_FETCH) begin
                                instr <= mem_rdata;
                            end else begin
                                mdr <= load_data;
                            end
                        end else begin
                            mem_req <= 1'b1;
                        end
                    end else if (!mem_ack) begin
                        // ack low again, the phase is over
                        ack_seen <= 1'b0;
                        if (state == S_FETCH) begin
                            state <= S_DECODE;
                        end else begin
                            state <= S_WB;
                        end
                    end
                end
                S_DECODE: state <= S_EXEC;
                S_EXEC: begin
                    if (dec.halt_req) begin
                        halted <= 1'b1;
                        state  <= S_WB;
                    end else if (dec.mem_read || dec.mem_write) begin
                        state <= S_MEM;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_WB: begin
                    pc <= next_pc;
                    if (halted) begin
                        state <= S_HALT;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_HALT: state <= S_HALT;
                default: state <= S_FETCH;
            endcase
        end
    end

    // four-phase rules seen from the core side
    assert property (@(posedge clk) disable iff (rst) $fell(mem_req) |-> $past(mem_ack))
        else $error("mem_req dropped before mem_ack");
    assert property (@(posedge clk) disable iff (rst) $rose(mem_req) |-> !$past(mem_ack))
        else $error("mem_req raised while mem_ack still high");

endmodule

// ==== hw/lsu.sv ====
// load/store unit for byte-lane store alignment, strobes and load extension
module lsu (
    decode_if.ctrl           dec,
    input  rv_pkg::word_t    addr,
    input  rv_pkg::word_t    store_val,
    input  rv_pkg::word_t    mem_word,
    output rv_pkg::word_t    wdata,
    output rv_pkg::byte_en_t be,
    output rv_pkg::word_t    load_data
);
    import rv_pkg::*;

    word_t shifted;

    // replicate the data, strobes pick the lanes
    always_comb begin
        case (dec.mem_width)
            MEM_BYTE: begin
                wdata = {4{store_val[7:0]}};
                be    = 4'b0001 << addr[1:0];
            end
            MEM_HALF: begin
                wdata = {2{store_val[15:0]}};
                be    = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata = store_val;
                be    = 4'b1111;
            end
        endcase
    end

    assign shifted = mem_word >> {addr[1:0], 3'b000};

    always_comb begin
        case (dec.mem_width)
            MEM_BYTE: load_data = {{24{dec.mem_sign_ext & shifted[7]}}, shifted[7:0]};
            MEM_HALF: load_data = {{16{dec.mem_sign_ext & shifted[15]}}, shifted[15:0]};
            default:  load_data = mem_word;
        endcase
    end

    // addr is the bus address, so outside the data phase it is the aligned pc
    always_comb begin
        if (dec.mem_read || dec.mem_write) begin
            assert final (!(dec.mem_width == MEM_HALF && addr[0]) &&
                          !(dec.mem_width == MEM_WORD && addr[1:0] != 2'b00))
                else $error("misaligned access at %h", addr);
        end
    end

endmodule

// ==== hw/alu.sv ====
// alu with operand muxes, funct3 operations and the branch comparator
module alu (
    decode_if.ctrl        dec,
    input  rv_pkg::word_t rs1_val,
    input  rv_pkg::word_t rs2_val,
    input  rv_pkg::word_t pc,
    output rv_pkg::word_t result,
    output logic          branch_taken
);
    import rv_pkg::*;

    word_t    op_a;
    word_t    op_b;
    logic [4:0] shamt;
    logic     cond;

    always_comb begin
        case (dec.alu_a_sel)
            A_PC:    op_a = pc;
            A_ZERO:  op_a = '0;
            default: op_a = rs1_val;
        endcase
        op_b = (dec.alu_b_sel == B_IMM) ? dec.imm : rs2_val;
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = dec.sub_arith ? op_a - op_b : op_a + op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SR:   result = dec.sub_arith ? word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
            ALU_OR:   result = op_a | op_b;
            default:  result = op_a & op_b;
        endcase
    end

    // branches compare the registers, the adder makes the target
    always_comb begin
        case (dec.branch_op)
            BR_EQ:   cond = rs1_val == rs2_val;
            BR_NE:   cond = rs1_val != rs2_val;
            BR_LT:   cond = $signed(rs1_val) < $signed(rs2_val);
            BR_GE:   cond = $signed(rs1_val) >= $signed(rs2_val);
            BR_LTU:  cond = rs1_val < rs2_val;
            BR_GEU:  cond = rs1_val >= rs2_val;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = dec.branch_always || (dec.branch_instr && cond);

endmodule

// ==== hw/reg_file.sv ====
// register file with 32 x 32-bit registers, two read ports and x0 held at zero
module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t ra1,
    input  rv_pkg::reg_idx_t ra2,
    input  rv_pkg::reg_idx_t wa,
    input  logic             we,
    input  rv_pkg::word_t    wd,
    output rv_pkg::word_t    rd1,
    output rv_pkg::word_t    rd2
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// ==== hw/instr_decoder.sv ====
// instruction decoder turning an rv32i word into immediates, register indices and selects
module instr_decoder (
    input rv_pkg::instr_t instr,
    decode_if.decoder     dec
);
    import rv_pkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign funct7 = instr.r_view.funct7;
    assign funct3 = instr.r_view.funct3;

    // every immediate takes its sign from instr[31]
    assign imm_i = {{20{funct7[6]}}, funct7, instr.r_view.rs2};
    assign imm_s = {{20{funct7[6]}}, funct7, instr.r_view.rd};
    assign imm_b = {{20{funct7[6]}}, instr.r_view.rd[0], funct7[5:0], instr.r_view.rd[4:1], 1'b0};
    assign imm_u = {instr.uj_view.upper, 12'b0};
    assign imm_j = {{12{instr.uj_view.upper[19]}}, instr.uj_view.upper[7:0],
                    instr.uj_view.upper[8], instr.uj_view.upper[18:9], 1'b0};

    assign dec.rs1 = instr.r_view.rs1;
    assign dec.rs2 = instr.r_view.rs2;
    assign dec.rd  = instr.uj_view.rd;

    always_comb begin
        // defaults give a no-op
        dec.imm           = '0;
        dec.alu_a_sel     = A_RS1;
        dec.alu_b_sel     = B_RS2;
        dec.alu_op        = ALU_ADD;
        dec.sub_arith     = 1'b0;
        dec.branch_instr  = 1'b0;
        dec.branch_always = 1'b0;
        dec.is_jalr       = 1'b0;
        dec.branch_op     = branch_op_t'(funct3);
        dec.mem_read      = 1'b0;
        dec.mem_write     = 1'b0;
        dec.mem_width     = mem_width_t'(funct3[1:0]);
        dec.mem_sign_ext  = !funct3[2];
        dec.wb_sel        = WB_ALU;
        dec.wb_en         = 1'b0;
        dec.halt_req      = 1'b0;

        case (instr.r_view.opcode)
            OP_LUI: begin
                dec.imm       = imm_u;
                dec.alu_a_sel = A_ZERO;
                dec.alu_b_sel = B_IMM;
                dec.wb_en     = 1'b1;
            end
            OP_AUIPC: begin
                dec.imm       = imm_u;
                dec.alu_a_sel = A_PC;
                dec.alu_b_sel = B_IMM;
                dec.wb_en     = 1'b1;
            end
            OP_JAL: begin
                dec.imm           = imm_j;
                dec.alu_a_sel     = A_PC;
                dec.alu_b_sel     = B_IMM;
                dec.branch_always = 1'b1;
                dec.wb_sel        = WB_PC_PLUS_4;
                dec.wb_en         = 1'b1;
            end
            OP_JALR: begin
                // target is rs1 + imm, bit 0 dropped in control
                dec.imm           = imm_i;
                dec.alu_b_sel     = B_IMM;
                dec.branch_always = 1'b1;
                dec.is_jalr       = 1'b1;
                dec.wb_sel        = WB_PC_PLUS_4;
                dec.wb_en         = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm          = imm_b;
                dec.alu_a_sel    = A_PC;
                dec.alu_b_sel    = B_IMM;
                dec.branch_instr = 1'b1;
            end
            OP_LOAD: begin
                dec.imm       = imm_i;
                dec.alu_b_sel = B_IMM;
                dec.mem_read  = 1'b1;
                dec.wb_sel    = WB_MEM;
                dec.wb_en     = 1'b1;
            end
            OP_STORE: begin
                dec.imm       = imm_s;
                dec.alu_b_sel = B_IMM;
                dec.mem_write = 1'b1;
            end
            OP_ALUI: begin
                dec.alu_b_sel = B_IMM;
                dec.alu_op    = alu_op_t'(funct3);
                dec.wb_en     = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    // shamt in rs2 field, bit 30 picks srai
                    dec.imm       = {27'b0, instr.r_view.rs2};
                    dec.sub_arith = funct7[5] && funct3[2];
                end else begin
                    dec.imm = imm_i;
                end
            end
            OP_ALU: begin
                dec.alu_op    = alu_op_t'(funct3);
                dec.sub_arith = funct7[5];
                dec.wb_en     = 1'b1;
            end
            OP_SYSTEM: begin
                // no csr support, any system op stops the core
                dec.halt_req = 1'b1;
            end
            default: begin
                // fence and unknown opcodes keep the no-op defaults
            end
        endcase
    end

endmodule

// ==== hw/decode_if.sv ====
// decoded control bundle from the instruction decoder to control and datapath
interface decode_if;
    import rv_pkg::*;

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    alu_op_t    alu_op;
    logic       sub_arith;
    logic       branch_instr;
    logic       branch_always;
    logic       is_jalr;
    branch_op_t branch_op;
    logic       mem_read;
    logic       mem_write;
    mem_width_t mem_width;
    logic       mem_sign_ext;
    wb_sel_t    wb_sel;
    logic       wb_en;
    logic       halt_req;

    modport decoder (
        output rs1, rs2, rd, imm, alu_a_sel, alu_b_sel, alu_op, sub_arith,
               branch_instr, branch_always, is_jalr, branch_op,
               mem_read, mem_write, mem_width, mem_sign_ext, wb_sel, wb_en, halt_req
    );

    modport ctrl (
        input rs1, rs2, rd, imm, alu_a_sel, alu_b_sel, alu_op, sub_arith,
              branch_instr, branch_always, is_jalr, branch_op,
              mem_read, mem_write, mem_width, mem_sign_ext, wb_sel, wb_en, halt_req
    );

endinterface

// ==== hw/rv_pkg.sv ====
// rv32i core package with base types, opcodes, mux selects and the instruction word union
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    // start address after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_ALUI   = 7'b0010011,
        OP_ALU    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // funct3 coded, sub/sra comes in sub_arith
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_op_t;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE = 2'b00, MEM_HALF = 2'b01, MEM_WORD = 2'b10} mem_width_t;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} alu_a_sel_t;
    typedef enum logic {B_RS2, B_IMM} alu_b_sel_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS_4} wb_sel_t;

    // one word, two decode views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            opcode_t    opcode;
        } r_view;
        struct packed {
            logic [19:0] upper;
            reg_idx_t    rd;
            opcode_t     opcode;
        } uj_view;
    } instr_t;

endpackage
